// ==== hw/command_decoder.sv ====
// byte parser for set_pixel, set_rgb_enable and set_brightness_enable
// no back-pressure; unknown opcodes are skipped while idle
`timescale 1ns/1ps
module command_decoder (
    input  logic                                     clk_root,
    input  logic                                     rst,
    input  logic [7:0]                               rx_data,
    input  logic                                     rx_valid,
    output led_matrix_pkg::fb_write_t                fb_write,
    output led_matrix_pkg::rgb_t                     rgb_enable,
    output logic [led_matrix_pkg::BRIGHT_BITS-1:0]   brightness_enable
);
    import led_matrix_pkg::*;

    localparam int XW = $clog2(COLS);
    localparam int YW = $clog2(ROW_PAIRS) + 1;

    opcode_e    cmd;
    logic       busy;     // command in progress
    logic [2:0] arg_cnt;
    logic       wr_en;
    fb_addr_t   wr_addr;
    pixel_t     wr_pix;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            cmd               <= set_pixel;
            busy              <= 1'b0;
            arg_cnt           <= '0;
            wr_en             <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid && !busy) begin
                arg_cnt <= '0;
                case (opcode_e'(rx_data))
                    set_pixel, set_rgb_enable, set_brightness_enable: begin
                        cmd  <= opcode_e'(rx_data);
                        busy <= 1'b1;
                    end
                    default: busy <= 1'b0; // unknown byte, stay idle
                endcase
            end else if (rx_valid) begin
                arg_cnt <= arg_cnt + 1'b1;
                case (cmd)
                    set_rgb_enable: begin
                        rgb_enable <= rgb_t'(rx_data[2:0]);
                        busy       <= 1'b0;
                    end
                    set_brightness_enable: begin
                        brightness_enable <= rx_data[BRIGHT_BITS-1:0];
                        busy              <= 1'b0;
                    end
                    default: begin
                        case (arg_cnt)
                            3'd0: wr_addr[XW-1:0]     <= rx_data[XW-1:0];
                            3'd1: wr_addr[XW+YW-1:XW] <= rx_data[YW-1:0];
                            3'd2: wr_pix.red          <= rx_data[BRIGHT_BITS-1:0];
                            3'd3: wr_pix.green        <= rx_data[BRIGHT_BITS-1:0];
                            default: begin
                                wr_pix.blue <= rx_data[BRIGHT_BITS-1:0];
                                wr_en       <= 1'b1; // write lands next cycle
                                busy        <= 1'b0;
                            end
                        endcase
                    end
                endcase
            end
        end
    end

    assign fb_write = '{we: wr_en, addr: wr_addr, data: wr_pix};

endmodule

// ==== hw/frame_buffer.sv ====
// one pixel per word, one write port and one registered read port
// contents are undefined until written
`timescale 1ns/1ps
module frame_buffer (
    input  logic                      clk_root,
    input  led_matrix_pkg::fb_write_t fb_write,
    input  led_matrix_pkg::fb_addr_t  rd_addr,
    output led_matrix_pkg::pixel_t    rd_data
);
    import led_matrix_pkg::*;

    localparam int DEPTH = 2 ** $bits(fb_addr_t);

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (fb_write.we) mem[fb_write.addr] <= fb_write.data;
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

// ==== hw/framebuffer_fetch.sv ====
// reads top then bottom pixel of a column, picks the plane bit per channel
// outputs are valid three cycles after load; masked by rgb_enable only
`timescale 1ns/1ps
module framebuffer_fetch (
    input  logic                      clk_root,
    input  logic                      rst,
    input  logic                      load,
    input  led_matrix_pkg::col_addr_t column,
    input  led_matrix_pkg::row_pair_t row_pair,
    input  led_matrix_pkg::plane_t    plane,
    input  led_matrix_pkg::rgb_t      rgb_enable,
    output led_matrix_pkg::fb_addr_t  rd_addr,
    input  led_matrix_pkg::pixel_t    rd_data,
    output led_matrix_pkg::rgb_t      rgb_top,
    output led_matrix_pkg::rgb_t      rgb_bottom
);
    import led_matrix_pkg::*;

    logic [1:0] step;      // 1: top data on bus, 2: bottom data on bus
    col_addr_t  col_q;
    row_pair_t  row_q;
    plane_t     plane_q;
    rgb_t       top_hold;

    function automatic rgb_t plane_bits(pixel_t px, plane_t p, rgb_t en);
        rgb_t b;
        b.red   = px.red[p];
        b.green = px.green[p];
        b.blue  = px.blue[p];
        return b & en;
    endfunction

    // top half first, straight from the request, then bottom half
    assign rd_addr = load ? {1'b0, row_pair, column} : {1'b1, row_q, col_q};

    always_ff @(posedge clk_root) begin
        if (rst) begin
            step       <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            case (step)
                2'd1: step <= 2'd2;
                2'd2: step <= 2'd0;
                default: step <= load ? 2'd1 : 2'd0;
            endcase
            if (step == 2'd2) begin
                rgb_top    <= top_hold;
                rgb_bottom <= plane_bits(rd_data, plane_q, rgb_enable);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load) begin
            col_q   <= column;
            row_q   <= row_pair;
            plane_q <= plane;
        end
        if (step == 2'd1) top_hold <= plane_bits(rd_data, plane_q, rgb_enable);
    end

endmodule

// ==== hw/led_matrix_pkg.sv ====
// shared geometry and types for the panel driver
// geometry is a fixed 8 x 8 test panel, 4-bit colour; edit here to resize
package led_matrix_pkg;

    localparam int COLS        = 8;
    localparam int ROW_PAIRS   = 4;
    localparam int BRIGHT_BITS = 4;

    typedef logic [$clog2(COLS)-1:0]        col_addr_t;
    typedef logic [$clog2(ROW_PAIRS)-1:0]   row_pair_t;
    typedef logic [$clog2(BRIGHT_BITS)-1:0] plane_t;
    typedef logic [$clog2(ROW_PAIRS)+$clog2(COLS):0] fb_addr_t; // {full row, column}

    typedef struct packed {
        logic [BRIGHT_BITS-1:0] red;
        logic [BRIGHT_BITS-1:0] green;
        logic [BRIGHT_BITS-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

    typedef struct packed {
        logic     we;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

    typedef struct packed {
        rgb_t      rgb_top;
        rgb_t      rgb_bottom;
        row_pair_t row_addr;
        logic      clk_pixel;
        logic      latch;
        logic      output_enable; // active high, board inverts
    } hub75_t;

    typedef enum logic [7:0] {
        set_pixel             = 8'h01,
        set_rgb_enable        = 8'h02,
        set_brightness_enable = 8'h03
    } opcode_e;

    typedef enum logic [1:0] {
        shift_low,
        shift_high,
        latch,
        display
    } scan_state_e;

endpackage

// ==== hw/led_matrix_top.sv ====
// serial command stream in, HUB75 panel signals out, all on clk_root
// output_enable is active high here
`timescale 1ns/1ps
module led_matrix_top #(
    parameter int unsigned TICKS_PER_BIT  = 4,
    parameter int unsigned OE_BASE_CYCLES = 8
) (
    input  logic                   clk_root,
    input  logic                   rst,
    input  logic                   serial_in,
    output led_matrix_pkg::hub75_t panel
);
    import led_matrix_pkg::*;

    logic [7:0]             rx_data;
    logic                   rx_valid;
    fb_write_t              fb_write;
    rgb_t                   rgb_enable;
    logic [BRIGHT_BITS-1:0] brightness_enable;
    fb_addr_t               rd_addr;
    pixel_t                 rd_data;
    logic                   load;
    col_addr_t              column;
    row_pair_t              row_pair;
    plane_t                 plane;
    row_pair_t              row_addr;
    rgb_t                   rgb_top;
    rgb_t                   rgb_bottom;
    logic                   clk_pixel;
    logic                   latch_out;
    logic                   output_enable;

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_rx_i (
        .clk_root (clk_root),
        .rst      (rst),
        .serial_in(serial_in),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder command_decoder_i (
        .clk_root         (clk_root),
        .rst              (rst),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .fb_write         (fb_write),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    frame_buffer frame_buffer_i (
        .clk_root(clk_root),
        .fb_write(fb_write),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    framebuffer_fetch framebuffer_fetch_i (
        .clk_root  (clk_root),
        .rst       (rst),
        .load      (load),
        .column    (column),
        .row_pair  (row_pair),
        .plane     (plane),
        .rgb_enable(rgb_enable),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rgb_top   (rgb_top),
        .rgb_bottom(rgb_bottom)
    );

    matrix_scan #(
        .OE_BASE_CYCLES(OE_BASE_CYCLES)
    ) matrix_scan_i (
        .clk_root         (clk_root),
        .rst              (rst),
        .brightness_enable(brightness_enable),
        .load             (load),
        .column           (column),
        .row_pair         (row_pair),
        .plane            (plane),
        .row_addr         (row_addr),
        .clk_pixel        (clk_pixel),
        .latch            (latch_out),
        .output_enable    (output_enable)
    );

    assign panel = '{rgb_top: rgb_top, rgb_bottom: rgb_bottom, row_addr: row_addr,
                     clk_pixel: clk_pixel, latch: latch_out, output_enable: output_enable};

endmodule

// ==== hw/matrix_scan.sv ====
// BCM scan: 4-cycle column slots, 1-cycle latch, display of OE_BASE_CYCLES << plane
// load is issued one cycle ahead of each slot so data settles before clk_pixel rises
`timescale 1ns/1ps
module matrix_scan #(
    parameter int unsigned OE_BASE_CYCLES = 8
) (
    input  logic                                   clk_root,
    input  logic                                   rst,
    input  logic [led_matrix_pkg::BRIGHT_BITS-1:0] brightness_enable,
    output logic                                   load,
    output led_matrix_pkg::col_addr_t              column,
    output led_matrix_pkg::row_pair_t              row_pair,
    output led_matrix_pkg::plane_t                 plane,
    output led_matrix_pkg::row_pair_t              row_addr,
    output logic                                   clk_pixel,
    output logic                                   latch,
    output logic                                   output_enable
);
    import led_matrix_pkg::*;

    localparam int DISP_W = $clog2(OE_BASE_CYCLES << (BRIGHT_BITS - 1)) + 1;

    scan_state_e       state;
    logic [1:0]        phase;
    col_addr_t         col_q;
    row_pair_t         row_q;      // row pair being shifted
    plane_t            plane_q;    // plane being shifted
    plane_t            disp_plane; // plane on display
    logic [DISP_W-1:0] disp_cnt;
    logic              showing;    // low for the dummy display right after reset

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state      <= display; // zero-length, kicks off row pair 0 plane 0
            phase      <= '0;
            col_q      <= '0;
            row_q      <= '0;
            plane_q    <= '0;
            disp_plane <= '0;
            disp_cnt   <= '0;
            showing    <= 1'b0;
            row_addr   <= '0;
        end else begin
            case (state)
                shift_low: begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd2) state <= shift_high;
                end
                shift_high: begin
                    phase <= '0;
                    col_q <= col_q + 1'b1;
                    if (col_q == col_addr_t'(COLS - 1)) begin
                        col_q <= '0;
                        state <= led_matrix_pkg::latch;
                    end else begin
                        state <= shift_low;
                    end
                end
                led_matrix_pkg::latch: begin
                    disp_cnt   <= DISP_W'((OE_BASE_CYCLES << plane_q) - 1);
                    disp_plane <= plane_q;
                    showing    <= 1'b1;
                    state      <= display;
                    if (plane_q == plane_t'(BRIGHT_BITS - 1)) begin
                        plane_q <= '0;
                        row_q   <= (row_q == row_pair_t'(ROW_PAIRS - 1)) ? '0 : row_q + 1'b1;
                    end else begin
                        plane_q <= plane_q + 1'b1;
                    end
                end
                default: begin // display
                    if (disp_cnt == '0) begin
                        state   <= shift_low;
                        phase   <= '0;
                        showing <= 1'b0;
                        if (plane_q == '0) row_addr <= row_q; // new row pair starts
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // request for the next slot
    assign load = (state == display && disp_cnt == '0)
                || (state == shift_high && col_q != col_addr_t'(COLS - 1));
    assign column   = (state == shift_high) ? col_q + 1'b1 : col_q;
    assign row_pair = row_q;
    assign plane    = plane_q;

    assign clk_pixel     = (state == shift_high);
    assign latch         = (state == led_matrix_pkg::latch);
    assign output_enable = (state == display) && showing && brightness_enable[disp_plane];

endmodule

// ==== hw/uart_rx.sv ====
// 8N1 receiver, LSB first; TICKS_PER_BIT clk_root cycles per bit, at least 2
// bytes with a low stop bit are dropped without a strobe
`timescale 1ns/1ps
module uart_rx #(
    parameter int unsigned TICKS_PER_BIT = 4
) (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_bits,
        rx_stop
    } rx_state_e;

    localparam int CNT_W = $clog2(2 * TICKS_PER_BIT);

    rx_state_e        state;
    logic [1:0]       sync;      // two-flop synchroniser
    logic             line_prev;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             stop_ok;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            sync      <= 2'b11;
            line_prev <= 1'b1;
            state     <= rx_idle;
            cnt       <= '0;
            bit_idx   <= '0;
            stop_ok   <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            sync      <= {sync[0], serial_in};
            line_prev <= sync[1];
            rx_valid  <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (line_prev && !sync[1]) state <= rx_start; // falling edge
                end
                rx_start: if (cnt == CNT_W'(TICKS_PER_BIT / 2 - 1)) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= sync[1] ? rx_idle : rx_bits; // glitch check at mid start bit
                end
                rx_bits: if (cnt == CNT_W'(TICKS_PER_BIT - 1)) begin
                    cnt     <= '0;
                    rx_data <= {sync[1], rx_data[7:1]}; // lsb arrives first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= rx_stop;
                end
                rx_stop: begin
                    if (cnt == CNT_W'(TICKS_PER_BIT - 1)) stop_ok <= sync[1];
                    // strobe half a bit after the stop sample
                    if (cnt == CNT_W'(TICKS_PER_BIT + TICKS_PER_BIT / 2 - 1)) begin
                        rx_valid <= stop_ok;
                        state    <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

// ==== led_matrix_top.f ====
hw/led_matrix_pkg.sv
hw/uart_rx.sv
hw/command_decoder.sv
hw/frame_buffer.sv
hw/framebuffer_fetch.sv
hw/matrix_scan.sv
hw/led_matrix_top.sv
verification/led_matrix_props.sv
verification/led_matrix_tb.sv

// ==== verification/led_matrix_input.txt ====
# word and decimal args: pixel x y red green blue | rgb mask | bright mask
# bad byte (low stop bit) | raw byte (good stop) | fill | check name
fill
check random_fill
pixel 3 5 15 0 10
check single_pixel
pixel 0 0 0 0 0
pixel 7 7 15 15 15
check corner_pixels
# mask bits are red green blue from bit 2 down
rgb 3
check red_off
rgb 7
# planes 0 and 2 on, 1 and 3 off
bright 5
check planes_off
bright 15
# would set rgb_enable from the next byte if it were accepted
bad 2
pixel 6 1 9 6 3
check bad_stop_byte
raw 170
pixel 2 6 4 12 7
check unknown_opcode

// ==== verification/led_matrix_props.sv ====
// timing rules on the HUB75 outputs and the framebuffer write strobe
// checked on clk_root, idle while rst is high
`timescale 1ns/1ps
module led_matrix_props (
    input logic                   clk_root,
    input logic                   rst,
    input led_matrix_pkg::hub75_t panel,
    input logic                   fb_we
);
    int prop_errors = 0; // read by the testbench at the end

    latch_oe_exclusive: assert property (@(posedge clk_root) disable iff (rst)
        !(panel.latch && panel.output_enable))
        else begin
            $error("latch and output_enable high in the same cycle");
            prop_errors++;
        end

    pixel_clock_quiet: assert property (@(posedge clk_root) disable iff (rst)
        (panel.latch || panel.output_enable) |-> !panel.clk_pixel)
        else begin
            $error("clk_pixel high during latch or display");
            prop_errors++;
        end

    // row address must hold for the whole display time
    row_stable_in_display: assert property (@(posedge clk_root) disable iff (rst)
        (panel.output_enable && $past(panel.output_enable)) |-> $stable(panel.row_addr))
        else begin
            $error("row_addr changed while output_enable high");
            prop_errors++;
        end

    write_single_cycle: assert property (@(posedge clk_root) disable iff (rst)
        fb_we |=> !fb_we)
        else begin
            $error("framebuffer write enable held for two cycles");
            prop_errors++;
        end

endmodule

bind led_matrix_top led_matrix_props props_i (
    .clk_root(clk_root),
    .rst     (rst),
    .panel   (panel),
    .fb_we   (fb_write.we)
);

// ==== verification/led_matrix_tb.sv ====
// drives 8N1 commands from verification/led_matrix_input.txt and checks whole frames
// rgb and output_enable are sampled on the falling clk_root edge
`timescale 1ns/1ps
module led_matrix_tb;
    import led_matrix_pkg::*;

    localparam int TICKS_PER_BIT  = 4;
    localparam int OE_BASE_CYCLES = 8;
    localparam int SLOT_CYCLES    = 4;
    localparam int FRAME_CYCLES   = ROW_PAIRS * (BRIGHT_BITS * (COLS * SLOT_CYCLES + 1)
                                    + OE_BASE_CYCLES * ((1 << BRIGHT_BITS) - 1));
    localparam int FRAME_TIMEOUT  = 2 * FRAME_CYCLES;

    logic   clk_root = 1'b0;
    logic   rst;
    logic   serial_in;
    hub75_t panel;

    pixel_t                 fb_model [COLS * 2 * ROW_PAIRS]; // index {full row, column}
    rgb_t                   rgb_model;
    logic [BRIGHT_BITS-1:0] bright_model;
    int                     error_count;
    int                     tests_run;
    int                     tests_failed;
    bit                     timed_out;

    led_matrix_top #(
        .TICKS_PER_BIT (TICKS_PER_BIT),
        .OE_BASE_CYCLES(OE_BASE_CYCLES)
    ) led_matrix_top_i (
        .clk_root (clk_root),
        .rst      (rst),
        .serial_in(serial_in),
        .panel    (panel)
    );

    always #4 clk_root = ~clk_root;

    task automatic value_error(input string name, input int expected, input int actual);
        $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        error_count++;
    endtask

    // a short line in the input file would send stale arguments
    task automatic arg_count_check(input int got, input int want, input string what);
        if (got != want) begin
            $display("input file line %s has %0d arguments, expected %0d", what, got, want);
            error_count++;
        end
    endtask

    // start, 8 data bits lsb first, stop, then two idle bits
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        int i;
        @(posedge clk_root);
        serial_in <= 1'b0;
        repeat (TICKS_PER_BIT) @(posedge clk_root);
        for (i = 0; i < 8; i++) begin
            serial_in <= data[i];
            repeat (TICKS_PER_BIT) @(posedge clk_root);
        end
        serial_in <= stop_bit;
        repeat (TICKS_PER_BIT) @(posedge clk_root);
        serial_in <= 1'b1;
        repeat (2 * TICKS_PER_BIT) @(posedge clk_root);
    endtask

    task automatic send_pixel(input int x, input int y, input int r, input int g, input int b);
        send_byte(set_pixel, 1'b1);
        send_byte(x[7:0], 1'b1);
        send_byte(y[7:0], 1'b1);
        send_byte(r[7:0], 1'b1);
        send_byte(g[7:0], 1'b1);
        send_byte(b[7:0], 1'b1);
        fb_model[y[2:0] * COLS + x[2:0]] = '{red: r[3:0], green: g[3:0], blue: b[3:0]};
    endtask

    task automatic fill_random();
        int x;
        int y;
        for (y = 0; y < 2 * ROW_PAIRS; y++)
            for (x = 0; x < COLS; x++)
                send_pixel(x, y, $urandom % 16, $urandom % 16, $urandom % 16);
    endtask

    // expected panel bits for one pixel in one brightness plane
    function automatic rgb_t model_bits(pixel_t px, int p);
        rgb_t bits;
        bits.red   = px.red[p] & rgb_model.red;
        bits.green = px.green[p] & rgb_model.green;
        bits.blue  = px.blue[p] & rgb_model.blue;
        return bits;
    endfunction

    task automatic check_frame(input bit compare_rgb);
        int   prev_row;
        int   wait_cnt;
        int   latch_cnt;
        int   edge_cnt;
        int   oe_cnt;
        int   row;
        int   plane;
        int   last_plane;
        bit   done;
        rgb_t exp_top;
        rgb_t exp_bot;
        done     = 1'b0;
        wait_cnt = 0;
        @(negedge clk_root);
        prev_row = panel.row_addr;
        while (!done) begin // frame starts where row_addr wraps to 0
            @(negedge clk_root);
            wait_cnt++;
            if (prev_row == ROW_PAIRS - 1 && panel.row_addr == 0) begin
                done = 1'b1;
            end else if (wait_cnt > FRAME_TIMEOUT) begin
                $display("timeout: no frame start seen within %0d cycles", FRAME_TIMEOUT);
                timed_out = 1'b1;
                done      = 1'b1;
            end
            prev_row = panel.row_addr;
        end
        latch_cnt = 0;
        edge_cnt  = 0;
        oe_cnt    = 0;
        wait_cnt  = 0;
        done      = timed_out;
        while (!done) begin
            @(negedge clk_root);
            wait_cnt++;
            row   = latch_cnt / BRIGHT_BITS;
            plane = latch_cnt % BRIGHT_BITS;
            if (panel.output_enable) oe_cnt++;
            if (panel.clk_pixel) begin
                if (latch_cnt > 0 && edge_cnt == 0) begin // display of previous plane is over
                    last_plane = (latch_cnt - 1) % BRIGHT_BITS;
                    if (oe_cnt != (bright_model[last_plane] ? OE_BASE_CYCLES << last_plane : 0))
                        value_error($sformatf("output_enable cycles plane %0d", last_plane),
                            bright_model[last_plane] ? OE_BASE_CYCLES << last_plane : 0, oe_cnt);
                end
                if (latch_cnt == ROW_PAIRS * BRIGHT_BITS) begin
                    done = 1'b1;
                end else begin
                    exp_top = model_bits(fb_model[row * COLS + edge_cnt], plane);
                    exp_bot = model_bits(fb_model[(row + ROW_PAIRS) * COLS + edge_cnt], plane);
                    if (compare_rgb && panel.rgb_top !== exp_top)
                        value_error($sformatf("rgb_top row %0d col %0d plane %0d",
                            row, edge_cnt, plane), exp_top, panel.rgb_top);
                    if (compare_rgb && panel.rgb_bottom !== exp_bot)
                        value_error($sformatf("rgb_bottom row %0d col %0d plane %0d",
                            row, edge_cnt, plane), exp_bot, panel.rgb_bottom);
                    edge_cnt++;
                end
            end
            if (panel.latch) begin
                if (edge_cnt != COLS) value_error("clk_pixel pulses before latch", COLS, edge_cnt);
                if (panel.row_addr != row) value_error("row_addr at latch", row, panel.row_addr);
                latch_cnt++;
                edge_cnt = 0;
                oe_cnt   = 0;
            end
            if (!done && wait_cnt > FRAME_TIMEOUT) begin
                $display("timeout: frame scan did not finish within %0d cycles", FRAME_TIMEOUT);
                timed_out = 1'b1;
                done      = 1'b1;
            end
        end
        if (timed_out) error_count++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (error_count == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - start_errors);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    a0;
        int    a1;
        int    a2;
        int    a3;
        int    a4;
        int    start_errors;
        string word;
        string line;
        rst          = 1'b1;
        serial_in    = 1'b1;
        rgb_model    = '1; // masks come out of reset all ones
        bright_model = '1;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(95530));
        repeat (5) @(posedge clk_root);
        rst <= 1'b0;
        @(negedge clk_root);
        start_errors = error_count;
        if (panel.clk_pixel !== 1'b0) value_error("clk_pixel after reset", 0, panel.clk_pixel);
        if (panel.latch !== 1'b0) value_error("latch after reset", 0, panel.latch);
        if (panel.output_enable !== 1'b0)
            value_error("output_enable after reset", 0, panel.output_enable);
        check_frame(1'b0); // framebuffer still unwritten
        finish_test("reset_scan", start_errors);
        start_errors = error_count;
        fd = $fopen("verification/led_matrix_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/led_matrix_input.txt");
            error_count++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", word) == 1) begin
                case (word)
                    "pixel": begin
                        code = $fscanf(fd, "%d %d %d %d %d", a0, a1, a2, a3, a4);
                        arg_count_check(code, 5, word);
                        send_pixel(a0, a1, a2, a3, a4);
                    end
                    "rgb": begin
                        code = $fscanf(fd, "%d", a0);
                        arg_count_check(code, 1, word);
                        send_byte(set_rgb_enable, 1'b1);
                        send_byte(a0[7:0], 1'b1);
                        rgb_model = rgb_t'(a0[2:0]);
                    end
                    "bright": begin
                        code = $fscanf(fd, "%d", a0);
                        arg_count_check(code, 1, word);
                        send_byte(set_brightness_enable, 1'b1);
                        send_byte(a0[7:0], 1'b1);
                        bright_model = a0[BRIGHT_BITS-1:0];
                    end
                    "bad": begin // low stop bit, receiver drops it
                        code = $fscanf(fd, "%d", a0);
                        arg_count_check(code, 1, word);
                        send_byte(a0[7:0], 1'b0);
                    end
                    "raw": begin // non-opcode byte while idle
                        code = $fscanf(fd, "%d", a0);
                        arg_count_check(code, 1, word);
                        send_byte(a0[7:0], 1'b1);
                    end
                    "fill": fill_random();
                    "check": begin
                        code = $fscanf(fd, "%s", line);
                        arg_count_check(code, 1, word);
                        check_frame(1'b1);
                        finish_test(line, start_errors);
                        start_errors = error_count;
                    end
                    "#": code = $fgets(line, fd);
                    default: begin
                        $display("unknown stimulus word %s in input file", word);
                        error_count++;
                    end
                endcase
            end
            $fclose(fd);
        end
        error_count += led_matrix_top_i.props_i.prop_errors;
        $display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
            tests_run, tests_failed, error_count, led_matrix_top_i.props_i.prop_errors);
        if (error_count == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
